// ==== dv/clock_gen.sv ====
`timescale 1ns/100ps

module clock_gen #(
  parameter int PERIOD = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(PERIOD / 2) clk = ~clk;

endmodule

// ==== dv/cpu_props.sv ====
`timescale 1ns/100ps

module cpu_props (
  input logic         clk,
  input logic         rst_n,
  input logic         inst_valid,
  input cpu_pkg::wb_t retire
);

  // fixed pipeline depth, no stalls
  issue_to_retire: assert property (
    @(posedge clk) disable iff (!rst_n) $past(inst_valid, 4) |-> retire.valid
  ) else $error("retire.valid missing four cycles after inst_valid");

  // quiet in reset and right after release
  quiet_in_reset: assert property (
    @(posedge clk) (!rst_n || !$past(rst_n)) |-> !retire.valid
  ) else $error("retire.valid high during or just after reset");

  valid_known: assert property (
    @(posedge clk) !$isunknown(retire.valid)
  ) else $error("retire.valid is unknown");

endmodule

// ==== dv/cpu_tb.sv ====
`timescale 1ns/100ps
`include "cpu_settings.svh"

module cpu_tb;

  import cpu_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int MAX_INSTS   = 160;
  localparam int DRAIN_LIMIT = 8;
  // every instruction costs its issue cycle plus at most three idle ones
  localparam int WATCHDOG_CYCLES = 200 + MAX_INSTS * 6;

  logic  clk;
  logic  rst_n;
  logic  inst_valid;
  inst_t inst;
  wb_t   retire;
  data_t model_regs [`NUM_REGS];
  data_t model_mem [`DMEM_DEPTH];
  wb_t   exp_q [$];
  int    issue_q [$];
  int    cycle_cnt = 0;
  int    seed = 32'hea431c9d;
  wb_t   mon_exp;
  int    mon_issue;

  clock_gen #(.PERIOD(CLK_PERIOD)) clock_gen_i (.clk(clk));

  cpu_core cpu_core_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .retire     (retire)
  );

  bind cpu_core cpu_props cpu_props_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .retire     (retire)
  );

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  ////////////////////
  // helpers

  task automatic stop_on_error();
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, want);
      stop_on_error();
    end
  endtask

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic int rand_reg();
    return 1 + int'(rand_word() % 32'd7);
  endfunction

  function automatic inst_t enc_r(input int rs, input int rt, input int rd, input logic [5:0] fn);
    return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'b00000, fn};
  endfunction

  function automatic inst_t enc_i(input logic [5:0] op, input int rs, input int rt, input int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  // architectural model run in program order
  task automatic model_exec(input inst_t ins);
    reg_addr_t rs;
    reg_addr_t rt;
    data_t     a;
    data_t     b;
    data_t     ea;
    wb_t       expected;
    rs = ins[25:21];
    rt = ins[20:16];
    // r0 always reads zero
    a  = (rs == '0) ? '0 : model_regs[rs];
    b  = (rt == '0) ? '0 : model_regs[rt];
    ea = a + {16'h0000, ins[15:0]};
    expected.valid = 1'b1;
    expected.write = 1'b0;
    expected.dst   = rt;
    expected.data  = a + b;
    case (ins[31:26])
      OP_RTYPE: begin
        expected.dst   = ins[15:11];
        expected.write = 1'b1;
        case (ins[5:0])
          FN_ADD:  expected.data = a + b;
          FN_SUB:  expected.data = a - b;
          FN_AND:  expected.data = a & b;
          FN_OR:   expected.data = a | b;
          FN_SLT:  expected.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: expected.write = 1'b0;
        endcase
      end
      OP_ADDI: begin
        expected.write = 1'b1;
        expected.data  = ea;
      end
      OP_ORI: begin
        expected.write = 1'b1;
        expected.data  = a | {16'h0000, ins[15:0]};
      end
      OP_LW: begin
        expected.write = 1'b1;
        expected.data  = model_mem[ea[`DMEM_ADDR_WIDTH-1:0]];
      end
      OP_SW: begin
        expected.data = ea;
        model_mem[ea[`DMEM_ADDR_WIDTH-1:0]] = b;
      end
      default: expected.write = 1'b0;
    endcase
    // r0 is never written
    if (expected.dst == '0) expected.write = 1'b0;
    if (expected.write) model_regs[expected.dst] = expected.data;
    exp_q.push_back(expected);
    issue_q.push_back(cycle_cnt);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      inst_valid = 1'b0;
    end
  endtask

  task automatic issue(input inst_t ins, input int gap);
    @(negedge clk);
    inst_valid = 1'b1;
    inst       = ins;
    model_exec(ins);
    idle_cycles(gap);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    idle_cycles(1);
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("ERROR: %0d instructions never retired", exp_q.size());
      stop_on_error();
    end
  endtask

  ////////////////////
  // tests

  task automatic reset_stays_quiet();
    repeat (10) begin
      @(negedge clk);
      check("retire.valid", 32'(retire.valid), 32'h0);
    end
  endtask

  // register file has no reset
  task automatic fill_registers();
    for (int r = 1; r < `NUM_REGS; r++) begin
      issue(enc_i(OP_ORI, 0, r, int'(rand_word())), 0);
    end
    drain();
  endtask

  task automatic independent_alu_ops();
    issue(enc_i(OP_ORI, 0, 1, 'h1234), 3);
    issue(enc_i(OP_ORI, 0, 2, 'h00ff), 3);
    issue(enc_i(OP_ADDI, 1, 3, 'h8001), 3);
    issue(enc_r(1, 2, 4, FN_ADD), 3);
    issue(enc_r(2, 1, 5, FN_SUB), 3);
    issue(enc_r(1, 2, 6, FN_AND), 3);
    issue(enc_r(1, 2, 7, FN_OR), 3);
    issue(enc_r(5, 1, 8, FN_SLT), 3);
    issue(enc_r(1, 5, 9, FN_SLT), 3);
    issue(enc_r(0, 2, 10, FN_SUB), 3);
    issue(enc_r(5, 10, 11, FN_SLT), 3);
    drain();
  endtask

  // distances 1, 2 and 3, plus ex/mem winning over wb
  task automatic forwarding_chain();
    issue(enc_i(OP_ORI, 0, 1, 'h0005), 0);
    issue(enc_i(OP_ADDI, 1, 2, 'h0003), 0);
    issue(enc_r(2, 1, 3, FN_ADD), 0);
    issue(enc_r(3, 1, 4, FN_SUB), 0);
    issue(enc_r(4, 2, 5, FN_OR), 0);
    issue(enc_i(OP_ADDI, 0, 6, 'h0001), 0);
    issue(enc_i(OP_ADDI, 0, 6, 'h0002), 0);
    issue(enc_r(6, 6, 7, FN_ADD), 0);
    issue(enc_r(7, 5, 8, FN_SLT), 0);
    drain();
  endtask

  task automatic memory_access();
    issue(enc_i(OP_ORI, 0, 1, 'h0010), 0);
    issue(enc_i(OP_ORI, 0, 2, 'hbeef), 0);
    issue(enc_i(OP_SW, 1, 2, 'h0000), 0);
    issue(enc_i(OP_SW, 1, 1, 'h0004), 0);
    // upper address bits fall outside the ram
    issue(enc_i(OP_SW, 0, 2, 'h0045), 0);
    issue(enc_i(OP_LW, 1, 3, 'h0000), 1);
    issue(enc_r(3, 3, 4, FN_ADD), 0);
    issue(enc_i(OP_LW, 1, 5, 'h0004), 1);
    issue(enc_i(OP_LW, 0, 6, 'h0005), 1);
    issue(enc_r(5, 6, 7, FN_OR), 0);
    issue(enc_i(OP_SW, 1, 7, 'h0008), 0);
    issue(enc_i(OP_LW, 1, 8, 'h0008), 1);
    issue(enc_r(8, 0, 9, FN_ADD), 0);
    issue(enc_i(OP_ADDI, 2, 0, 'h0007), 0);
    issue(enc_r(0, 2, 10, FN_ADD), 0);
    issue(enc_r(0, 0, 11, FN_OR), 0);
    drain();
  endtask

  task automatic random_stream();
    logic [31:0] pick;
    int          rd;
    int          rs;
    int          rt;
    for (int n = 0; n < 40; n++) begin
      pick = rand_word();
      rd   = rand_reg();
      rs   = rand_reg();
      rt   = rand_reg();
      case (pick[2:0])
        3'd0:    issue(enc_r(rs, rt, rd, FN_ADD), 32'(pick[9:8]));
        3'd1:    issue(enc_r(rs, rt, rd, FN_SUB), 32'(pick[9:8]));
        3'd2:    issue(enc_r(rs, rt, rd, FN_AND), 32'(pick[9:8]));
        3'd3:    issue(enc_r(rs, rt, rd, FN_OR), 32'(pick[9:8]));
        3'd4:    issue(enc_r(rs, rt, rd, FN_SLT), 32'(pick[9:8]));
        3'd5:    issue(enc_i(OP_ADDI, rs, rd, 32'(pick[31:16])), 32'(pick[9:8]));
        3'd6:    issue(enc_i(OP_ORI, rs, rd, 32'(pick[31:16])), 32'(pick[9:8]));
        default: issue(enc_r(rs, rt, rd, FN_SLT), 32'(pick[9:8]));
      endcase
    end
    drain();
  endtask

  ////////////////////
  // monitor, watchdog, main

  always @(negedge clk) begin
    if (retire.valid) begin
      if (exp_q.size() == 0) begin
        $display("ERROR: retire at %0t with no instruction outstanding", $time);
        stop_on_error();
      end else begin
        mon_exp   = exp_q.pop_front();
        mon_issue = issue_q.pop_front();
        check("retire.write", 32'(retire.write), 32'(mon_exp.write));
        check("retire.dst", 32'(retire.dst), 32'(mon_exp.dst));
        check("retire.data", retire.data, mon_exp.data);
        check("retire latency", cycle_cnt - mon_issue, 32'd4);
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("ERROR: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    stop_on_error();
  end

  initial begin
    rst_n      = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    reset_stays_quiet();
    fill_registers();
    independent_alu_ops();
    forwarding_chain();
    memory_access();
    random_stream();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+verilog
verilog/cpu_pkg.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/cpu_core.sv
dv/clock_gen.sv
dv/cpu_props.sv
dv/cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module cpu_tb -f files.f -o cpu_tb_sim

output=$(./obj_dir/cpu_tb_sim 2>&1) || true
echo "$output"

if grep -q "Test completed successfully" <<< "$output"; then
  exit 0
fi
echo "simulation did not pass"
exit 1

// ==== verilog/cpu_core.sv ====
`timescale 1ns/100ps

module cpu_core (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           inst_valid,
  input  cpu_pkg::inst_t inst,
  output cpu_pkg::wb_t   retire
);

  import cpu_pkg::*;

  id_ex_t  id_ex;
  ex_mem_t ex_mem;

  ////////////////////
  // decode

  decode_stage decode_stage_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .wb         (retire),
    .id_ex      (id_ex)
  );

  ////////////////////
  // execute

  execute_stage execute_stage_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .id_ex  (id_ex),
    .wb     (retire),
    .ex_mem (ex_mem)
  );

  ////////////////////
  // memory and writeback

  // wb doubles as register write port and retire strobe
  memory_stage memory_stage_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .ex_mem (ex_mem),
    .wb     (retire)
  );

endmodule

// ==== verilog/cpu_pkg.sv ====
`include "cpu_settings.svh"

package cpu_pkg;

  typedef logic [`DATA_WIDTH-1:0]     data_t;
  typedef logic [`INST_WIDTH-1:0]     inst_t;
  typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;
  typedef logic [`IMM_WIDTH-1:0]      imm_t;

  ////////////////////
  // encodings

  typedef enum logic [`OPCODE_MSB-`OPCODE_LSB:0] {
    OP_RTYPE = 6'h00,
    OP_ADDI  = 6'h08,
    OP_ORI   = 6'h0d,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b
  } opcode_t;

  // r-type only
  typedef enum logic [`FUNCT_MSB-`FUNCT_LSB:0] {
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    FN_SLT = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4
  } alu_op_t;

  ////////////////////
  // stage registers

  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    use_imm;
    alu_op_t alu_op;
  } ctrl_t;

  typedef struct packed {
    logic      valid;
    ctrl_t     ctrl;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t dst;
    data_t     rs_data;
    data_t     rt_data;
    imm_t      imm;
  } id_ex_t;

  typedef struct packed {
    logic      valid;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    reg_addr_t dst;
    data_t     alu_result;
    data_t     store_data;
  } ex_mem_t;

  // register write port and retire strobe
  typedef struct packed {
    logic      valid;
    logic      write;
    reg_addr_t dst;
    data_t     data;
  } wb_t;

endpackage

// ==== verilog/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath widths
`define DATA_WIDTH      32
`define INST_WIDTH      32
`define NUM_REGS        32
`define REG_ADDR_WIDTH  5
`define IMM_WIDTH       16

// data ram, in words
`define DMEM_DEPTH      64
`define DMEM_ADDR_WIDTH 6

// instruction fields
`define OPCODE_MSB 31
`define OPCODE_LSB 26
`define RS_MSB     25
`define RS_LSB     21
`define RT_MSB     20
`define RT_LSB     16
`define RD_MSB     15
`define RD_LSB     11
`define IMM_MSB    15
`define IMM_LSB    0
`define FUNCT_MSB  5
`define FUNCT_LSB  0

`endif

// ==== verilog/decode_stage.sv ====
`timescale 1ns/100ps
`include "cpu_settings.svh"

module decode_stage (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            inst_valid,
  input  cpu_pkg::inst_t  inst,
  input  cpu_pkg::wb_t    wb,
  output cpu_pkg::id_ex_t id_ex
);

  import cpu_pkg::*;

  logic      inst_valid_q;
  inst_t     inst_q;
  opcode_t   opcode;
  funct_t    funct;
  reg_addr_t rs;
  reg_addr_t rt;
  reg_addr_t rd;
  reg_addr_t dst;
  imm_t      imm;
  ctrl_t     ctrl;
  data_t     rs_data;
  data_t     rt_data;
  data_t     regs [`NUM_REGS];

  // r0 reads zero, same-cycle write is passed through
  function automatic data_t rf_read(reg_addr_t idx, data_t entry, wb_t wr);
    data_t val;
    if (idx == '0) begin
      val = '0;
    end else if (wr.write && wr.dst == idx) begin
      val = wr.data;
    end else begin
      val = entry;
    end
    return val;
  endfunction

  ////////////////////
  // instruction capture

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inst_valid_q <= 1'b0;
    end else begin
      inst_valid_q <= inst_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_valid) begin
      inst_q <= inst;
    end
  end

  assign opcode = opcode_t'(inst_q[`OPCODE_MSB:`OPCODE_LSB]);
  assign funct  = funct_t'(inst_q[`FUNCT_MSB:`FUNCT_LSB]);
  assign rs     = inst_q[`RS_MSB:`RS_LSB];
  assign rt     = inst_q[`RT_MSB:`RT_LSB];
  assign rd     = inst_q[`RD_MSB:`RD_LSB];
  assign imm    = inst_q[`IMM_MSB:`IMM_LSB];

  ////////////////////
  // control

  always_comb begin
    ctrl = '0;
    case (opcode)
      OP_RTYPE: begin
        ctrl.reg_write = 1'b1;
        case (funct)
          FN_ADD:  ctrl.alu_op = ALU_ADD;
          FN_SUB:  ctrl.alu_op = ALU_SUB;
          FN_AND:  ctrl.alu_op = ALU_AND;
          FN_OR:   ctrl.alu_op = ALU_OR;
          FN_SLT:  ctrl.alu_op = ALU_SLT;
          default: ctrl.reg_write = 1'b0;
        endcase
      end
      OP_ADDI: begin
        ctrl.reg_write = 1'b1;
        ctrl.use_imm   = 1'b1;
      end
      OP_ORI: begin
        ctrl.reg_write = 1'b1;
        ctrl.use_imm   = 1'b1;
        ctrl.alu_op    = ALU_OR;
      end
      OP_LW: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.use_imm   = 1'b1;
      end
      OP_SW: begin
        ctrl.mem_write = 1'b1;
        ctrl.use_imm   = 1'b1;
      end
      // anything else still retires, writing nothing
      default: ctrl = '0;
    endcase
  end

  assign dst = (opcode == OP_RTYPE) ? rd : rt;

  ////////////////////
  // register file

  always_ff @(posedge clk) begin
    if (wb.write) begin
      regs[wb.dst] <= wb.data;
    end
  end

  assign rs_data = rf_read(rs, regs[rs], wb);
  assign rt_data = rf_read(rt, regs[rt], wb);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex.valid <= 1'b0;
      id_ex.ctrl  <= '0;
    end else begin
      id_ex.valid   <= inst_valid_q;
      id_ex.ctrl    <= inst_valid_q ? ctrl : ctrl_t'('0);
      id_ex.rs      <= rs;
      id_ex.rt      <= rt;
      id_ex.dst     <= dst;
      id_ex.rs_data <= rs_data;
      id_ex.rt_data <= rt_data;
      id_ex.imm     <= imm;
    end
  end

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/100ps
`include "cpu_settings.svh"

module execute_stage (
  input  logic             clk,
  input  logic             rst_n,
  input  cpu_pkg::id_ex_t  id_ex,
  input  cpu_pkg::wb_t     wb,
  output cpu_pkg::ex_mem_t ex_mem
);

  import cpu_pkg::*;

  data_t op_a;
  data_t rt_fwd;
  data_t op_b;
  data_t imm_ext;
  data_t alu_result;
  logic  slt;

  // newest producer wins, loads are not taken from ex/mem
  function automatic data_t forward(reg_addr_t idx, data_t rf_val, ex_mem_t em, wb_t wr);
    data_t val;
    if (em.reg_write && !em.mem_read && em.dst != '0 && em.dst == idx) begin
      val = em.alu_result;
    end else if (wr.write && wr.dst != '0 && wr.dst == idx) begin
      val = wr.data;
    end else begin
      val = rf_val;
    end
    return val;
  endfunction

  ////////////////////
  // operands

  assign op_a   = forward(id_ex.rs, id_ex.rs_data, ex_mem, wb);
  assign rt_fwd = forward(id_ex.rt, id_ex.rt_data, ex_mem, wb);

  // zero extended, also for addi and memory offsets
  assign imm_ext = {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, id_ex.imm};

  assign op_b = id_ex.ctrl.use_imm ? imm_ext : rt_fwd;

  ////////////////////
  // alu

  assign slt = $signed(op_a) < $signed(op_b);

  always_comb begin
    case (id_ex.ctrl.alu_op)
      ALU_ADD: alu_result = op_a + op_b;
      ALU_SUB: alu_result = op_a - op_b;
      ALU_AND: alu_result = op_a & op_b;
      ALU_OR:  alu_result = op_a | op_b;
      ALU_SLT: alu_result = {{(`DATA_WIDTH-1){1'b0}}, slt};
      default: alu_result = op_a + op_b;
    endcase
  end

  ////////////////////
  // ex/mem register

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_mem.valid     <= 1'b0;
      ex_mem.reg_write <= 1'b0;
      ex_mem.mem_read  <= 1'b0;
      ex_mem.mem_write <= 1'b0;
    end else begin
      ex_mem.valid      <= id_ex.valid;
      ex_mem.reg_write  <= id_ex.ctrl.reg_write;
      ex_mem.mem_read   <= id_ex.ctrl.mem_read;
      ex_mem.mem_write  <= id_ex.ctrl.mem_write;
      ex_mem.dst        <= id_ex.dst;
      // address for loads and stores
      ex_mem.alu_result <= alu_result;
      ex_mem.store_data <= rt_fwd;
    end
  end

endmodule

// ==== verilog/memory_stage.sv ====
`timescale 1ns/100ps
`include "cpu_settings.svh"

module memory_stage (
  input  logic             clk,
  input  logic             rst_n,
  input  cpu_pkg::ex_mem_t ex_mem,
  output cpu_pkg::wb_t     wb
);

  import cpu_pkg::*;

  data_t                       dmem [`DMEM_DEPTH];
  logic [`DMEM_ADDR_WIDTH-1:0] addr;
  data_t                       ram_q;
  logic                        load_q;
  wb_t                         wb_q;

  // word addressed, upper address bits ignored
  assign addr = ex_mem.alu_result[`DMEM_ADDR_WIDTH-1:0];

  ////////////////////
  // data ram

  always_ff @(posedge clk) begin
    if (ex_mem.mem_write) begin
      dmem[addr] <= ex_mem.store_data;
    end
  end

  // registered read, lines up with wb_q
  always_ff @(posedge clk) begin
    ram_q <= dmem[addr];
  end

  ////////////////////
  // mem/wb register

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_q.valid <= 1'b0;
      wb_q.write <= 1'b0;
      load_q     <= 1'b0;
    end else begin
      wb_q.valid <= ex_mem.valid;
      wb_q.write <= ex_mem.reg_write && (ex_mem.dst != '0);
      wb_q.dst   <= ex_mem.dst;
      wb_q.data  <= ex_mem.alu_result;
      load_q     <= ex_mem.mem_read;
    end
  end

  // result select
  always_comb begin
    wb = wb_q;
    if (load_q) begin
      wb.data = ram_q;
    end
  end

endmodule
